// ==== Bender.yml ====
package:
  name: ctrl_core

sources:
  - include_dirs:
      - .
    files:
      - ctrl_pkg.sv
      - host_bus_decoder.sv
      - settings_bus.sv
      - misc_setting_regs.sv
      - vita_time_counter.sv
      - readback_mux.sv
      - ctrl_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - ctrl_core_tb.sv

// ==== ctrl_core.f ====
+incdir+.
ctrl_pkg.sv
host_bus_decoder.sv
settings_bus.sv
misc_setting_regs.sv
vita_time_counter.sv
readback_mux.sv
ctrl_core.sv
ctrl_core_tb.sv

// ==== ctrl_core.sv ====
module ctrl_core (
   input  logic                dsp_clk,
   input  logic                por_rst,
   // Host bus
   input  ctrl_pkg::bus_addr_t bus_adr_i,
   input  ctrl_pkg::bus_data_t bus_dat_i,
   input  logic                bus_we_i,
   input  logic                bus_stb_i,
   output ctrl_pkg::bus_data_t bus_dat_o,
   output logic                bus_ack_o,
   output logic                bus_err_o,
   // Board inputs
   input  logic                pps_i,
   input  logic                clk_status_i,
   input  logic                button_i,
   // Control outputs
   output logic                clock_ready_o,
   output logic [1:0]          clk_en_o,
   output logic [1:0]          clk_sel_o,
   output logic                phy_resetn_o,
   output logic                divsw1_o,
   output logic                divsw2_o,
   output logic [7:0]          leds_o,
   output logic                pps_int_o
);
   import ctrl_pkg::*;

   logic       set_sel;
   logic       rb_sel;
   logic       set_ack;
   logic       rb_ack;
   bus_data_t  rb_dat;
   logic       set_stb;
   set_addr_t  set_addr;
   set_data_t  set_data;
   vita_time_u vita_time;
   vita_time_u vita_time_pps;
   logic       good_sync;

   ////////////////////////////////////////////////////////////////////////////
   // Host side

   host_bus_decoder u_decoder (
      .dsp_clk   (dsp_clk),
      .por_rst   (por_rst),
      .bus_adr_i (bus_adr_i),
      .bus_stb_i (bus_stb_i),
      .set_ack_i (set_ack),
      .rb_ack_i  (rb_ack),
      .rb_dat_i  (rb_dat),
      .set_sel_o (set_sel),
      .rb_sel_o  (rb_sel),
      .bus_dat_o (bus_dat_o),
      .bus_ack_o (bus_ack_o),
      .bus_err_o (bus_err_o)
   );

   settings_bus u_settings_bus (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .bus_adr_i  (bus_adr_i),
      .bus_dat_i  (bus_dat_i),
      .bus_we_i   (bus_we_i),
      .set_sel_i  (set_sel),
      .set_ack_o  (set_ack),
      .set_stb_o  (set_stb),
      .set_addr_o (set_addr),
      .set_data_o (set_data)
   );

   readback_mux u_readback (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .bus_adr_i       (bus_adr_i),
      .rb_sel_i        (rb_sel),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps),
      .good_sync_i     (good_sync),
      .clk_status_i    (clk_status_i),
      .button_i        (button_i),
      .rb_ack_o        (rb_ack),
      .rb_dat_o        (rb_dat)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Settings consumers

   misc_setting_regs u_misc (
      .dsp_clk       (dsp_clk),
      .por_rst       (por_rst),
      .set_stb_i     (set_stb),
      .set_addr_i    (set_addr),
      .set_data_i    (set_data),
      .clk_status_i  (clk_status_i),
      .good_sync_i   (good_sync),
      .clock_ready_o (clock_ready_o),
      .clk_en_o      (clk_en_o),
      .clk_sel_o     (clk_sel_o),
      .phy_resetn_o  (phy_resetn_o),
      .divsw1_o      (divsw1_o),
      .divsw2_o      (divsw2_o),
      .leds_o        (leds_o)
   );

   vita_time_counter u_time (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .set_stb_i       (set_stb),
      .set_addr_i      (set_addr),
      .set_data_i      (set_data),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .good_sync_o     (good_sync),
      .pps_int_o       (pps_int_o)
   );

endmodule

// ==== ctrl_core_tb.sv ====
`include "ctrl_params.svh"

module ctrl_core_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import ctrl_pkg::*;

   localparam int unsigned SEED           = 32'hdb7cbcfa;
   localparam int          TIMEOUT_CYCLES = 5000;   // Full run is about 200 cycles

   logic       dsp_clk;
   logic       por_rst;
   bus_addr_t  bus_adr;
   bus_data_t  bus_wdat;
   logic       bus_we;
   logic       bus_stb;
   bus_data_t  bus_rdat;
   logic       bus_ack;
   logic       bus_err;
   logic       pps;
   logic       clk_status;
   logic       button;
   logic       clock_ready;
   logic [1:0] clk_en;
   logic [1:0] clk_sel;
   logic       phy_resetn;
   logic       divsw1;
   logic       divsw2;
   logic [7:0] leds;
   logic       pps_int;
   int         check_count;
   int         error_count;
   int         cycle_count;

   ctrl_core dut (
      .dsp_clk       (dsp_clk),
      .por_rst       (por_rst),
      .bus_adr_i     (bus_adr),
      .bus_dat_i     (bus_wdat),
      .bus_we_i      (bus_we),
      .bus_stb_i     (bus_stb),
      .bus_dat_o     (bus_rdat),
      .bus_ack_o     (bus_ack),
      .bus_err_o     (bus_err),
      .pps_i         (pps),
      .clk_status_i  (clk_status),
      .button_i      (button),
      .clock_ready_o (clock_ready),
      .clk_en_o      (clk_en),
      .clk_sel_o     (clk_sel),
      .phy_resetn_o  (phy_resetn),
      .divsw1_o      (divsw1),
      .divsw2_o      (divsw2),
      .leds_o        (leds),
      .pps_int_o     (pps_int)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #5 dsp_clk = ~dsp_clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers

   // Just after the next rising edge, where inputs change and outputs are read
   task automatic next_cycle();
      @(posedge dsp_clk);
      #1;
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      end
   endtask

   function automatic bus_addr_t set_byte_addr(input int word);
      return {`SET_REGION, 2'b00, word[7:0], 2'b00};
   endfunction

   function automatic bus_addr_t rb_byte_addr(input int word);
      return {`RB_REGION, 6'b000000, word[3:0], 2'b00};
   endfunction

   // Hardware LEDs: bit 1 clock status, bit 2 time sync
   function automatic logic [7:0] led_expect(input logic [7:0] src, input logic [7:0] sw,
                                             input logic clk_st, input logic sync);
      logic [7:0] hw;
      logic [7:0] res;
      hw    = 8'h00;
      hw[1] = clk_st;
      hw[2] = sync;
      for (int i = 0; i < 8; i++)
         res[i] = src[i] ? hw[i] : sw[i];
      return res;
   endfunction

   function automatic bus_data_t status_expect(input logic sync);
      bus_data_t w;
      w     = '0;
      w[13] = button;
      w[11] = clk_status;
      w[10] = sync;
      return w;
   endfunction

   // One access, then one idle cycle with the strobe low
   task automatic bus_cycle(input bus_addr_t adr, input logic we, input bus_data_t wdat,
                            output bus_data_t rdat, output logic ack, output logic err);
      bus_adr  = adr;
      bus_we   = we;
      bus_wdat = wdat;
      bus_stb  = 1'b1;
      do begin
         next_cycle();
      end while (!bus_ack && !bus_err);
      ack     = bus_ack;
      err     = bus_err;
      rdat    = bus_rdat;                // Valid in the ack cycle
      bus_stb = 1'b0;
      bus_we  = 1'b0;
      next_cycle();
   endtask

   // Returns one cycle after the ack, when the setting has landed
   task automatic bus_write(input int word, input bus_data_t data);
      bus_data_t rdat;
      logic      ack;
      logic      err;
      bus_cycle(set_byte_addr(word), 1'b1, data, rdat, ack, err);
      if (!ack) begin
         error_count++;
         $display("ERROR: write to setting %0d was not acknowledged", word);
      end
   endtask

   task automatic bus_read(input int word, output bus_data_t data);
      logic ack;
      logic err;
      bus_cycle(rb_byte_addr(word), 1'b0, '0, data, ack, err);
      if (!ack) begin
         error_count++;
         $display("ERROR: read of word %0d was not acknowledged", word);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests

   task automatic test_reset_state();
      bus_data_t rdat;
      check_value("bus_ack_o", bus_ack, 1'b0);
      check_value("bus_err_o", bus_err, 1'b0);
      check_value("divsw1_o", divsw1, 1'b1);
      check_value("divsw2_o", divsw2, 1'b1);
      check_value("phy_resetn_o", phy_resetn, 1'b1);
      check_value("clock_ready_o", clock_ready, 1'b0);
      check_value("clk_en_o", clk_en, 2'b00);
      check_value("clk_sel_o", clk_sel, 2'b00);
      check_value("pps_int_o", pps_int, 1'b0);
      check_value("leds_o", leds, led_expect(8'h1E, 8'h00, clk_status, 1'b0));
      bus_read(12, rdat);
      check_value("compat word", rdat, 32'h0008_0002);
      bus_read(13, rdat);
      check_value("status word", rdat, status_expect(1'b0));
   endtask

   task automatic test_setting_regs();
      bus_data_t d;
      for (int i = 0; i < 4; i++) begin
         d = $urandom();
         bus_write(`SR_MISC + 0, d);
         check_value("clock_ready_o", clock_ready, d[4]);
         check_value("clk_en_o", clk_en, d[3:2]);
         check_value("clk_sel_o", clk_sel, d[1:0]);
         d = $urandom();
         bus_write(`SR_MISC + 4, d);
         check_value("phy_resetn_o", phy_resetn, !d[0]);   // Active low pin
         d = $urandom();
         bus_write(`SR_DIVSW + 0, d);
         check_value("divsw1_o", divsw1, d[0]);
         d = $urandom();
         bus_write(`SR_DIVSW + 1, d);
         check_value("divsw2_o", divsw2, d[0]);
      end
   endtask

   task automatic test_led_mux();
      logic [7:0] sw;
      logic [7:0] src;
      sw = 8'($urandom());
      bus_write(`SR_MISC + 6, 32'h0);       // All software
      bus_write(`SR_MISC + 3, sw);
      check_value("leds_o", leds, sw);
      // Bit 1 from hardware, bit 2 from software, the rest random
      src = (8'($urandom()) | 8'h02) & 8'hFB;
      bus_write(`SR_MISC + 6, src);
      for (int i = 0; i < 4; i++) begin
         clk_status = ~clk_status;
         next_cycle();
         check_value("leds_o", leds, led_expect(src, sw, clk_status, 1'b0));
      end
      bus_write(`SR_MISC + 6, 8'h1E);
   endtask

   task automatic test_immediate_load();
      bus_data_t secs;
      bus_data_t rdat;
      secs = $urandom() & 32'h0fff_ffff;
      bus_write(`SR_TIME64 + 0, secs);
      bus_write(`SR_TIME64 + 1, 32'd13000000 - 32'd20);   // 20 ticks before rollover
      bus_write(`SR_TIME64 + 2, 32'd1);
      repeat (40) next_cycle();
      bus_read(10, rdat);
      check_value("time secs", rdat, secs + 32'd1);
      bus_read(11, rdat);
      check_value("time ticks below 40", rdat < 32'd40, 1'b1);
   endtask

   task automatic test_pps_load();
      bus_data_t secs;
      bus_data_t secs2;
      bus_data_t ticks0;
      bus_data_t rdat;
      int        pulses;
      int        first_pulse;
      secs   = $urandom() & 32'h0fff_ffff;
      secs2  = $urandom() & 32'h0fff_ffff;
      ticks0 = $urandom() & 32'h000f_ffff;  // Far below rollover
      bus_write(`SR_TIME64 + 0, secs);
      bus_write(`SR_TIME64 + 1, ticks0);
      bus_write(`SR_TIME64 + 2, 32'd1);
      bus_write(`SR_TIME64 + 0, secs2);
      bus_write(`SR_TIME64 + 2, 32'd0);     // Arm for the next PPS
      pulses      = 0;
      first_pulse = 0;
      pps         = 1'b1;
      for (int i = 1; i <= 8; i++) begin
         next_cycle();
         if (pps_int) begin
            pulses++;
            if (first_pulse == 0)
               first_pulse = i;
         end
      end
      pps = 1'b0;
      check_value("pps_int_o pulse count", pulses, 1);
      if (first_pulse > 5) begin
         error_count++;
         $display("ERROR: pps_int_o came %0d cycles after the PPS edge", first_pulse);
      end
      bus_read(14, rdat);
      check_value("pps time secs", rdat, secs);
      // Counted up from the loaded ticks for a dozen cycles or so
      bus_read(15, rdat);
      check_value("pps time ticks in window",
                  (rdat >= ticks0) && (rdat < ticks0 + 32'd20), 1'b1);
      bus_read(10, rdat);
      check_value("time secs", rdat, secs2);
      bus_read(13, rdat);
      check_value("status word", rdat, status_expect(1'b1));
      check_value("leds_o[2]", leds[2], 1'b1);
   endtask

   task automatic test_unmapped_access();
      bus_data_t rdat;
      logic      ack;
      logic      err;
      bus_cycle(16'h9000, 1'b0, '0, rdat, ack, err);
      check_value("bus_err_o", err, 1'b1);
      check_value("bus_ack_o", ack, 1'b0);
      check_value("bus_err_o after access", bus_err, 1'b0);
      bus_read(12, rdat);
      check_value("compat word", rdat, 32'h0008_0002);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Run control

   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge dsp_clk);
         cycle_count++;
      end
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      int unsigned seed;
      seed        = SEED;
      seed        = $urandom(seed);
      check_count = 0;
      error_count = 0;
      por_rst     = 1'b1;
      bus_adr     = '0;
      bus_wdat    = '0;
      bus_we      = 1'b0;
      bus_stb     = 1'b0;
      pps         = 1'b0;
      clk_status  = 1'b1;
      button      = 1'b1;
      repeat (4) @(posedge dsp_clk);
      #1;
      por_rst = 1'b0;
      next_cycle();

      test_reset_state();
      test_setting_regs();
      test_led_mux();
      test_immediate_load();
      test_pps_load();
      test_unmapped_access();

      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== ctrl_params.svh ====
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Settings bus map, word addresses

`define SR_MISC        32'd0      // Clock ctrl +0, LED sw +3, PHY +4, LED src +6
`define SR_TIME64      32'd10     // Secs +0, ticks +1, load cmd +2
`define SR_DIVSW       32'd180    // Two diversity switches

// LEDs 1..4 follow hardware out of reset
`define LED_SRC_RESET  8'h1E

////////////////////////////////////////////////////////////////////////////
// Identification and timing

// Bump when the register map changes in a way software can see
`define COMPAT_MAJOR   16'd8
`define COMPAT_MINOR   16'd2

`define TICKS_PER_SEC  32'd13000000   // dsp_clk rate

////////////////////////////////////////////////////////////////////////////
// Host bus regions, upper address nibble

`define RB_REGION      4'h5       // Readback words
`define SET_REGION     4'h7       // Settings writes

// Everything else on the host bus errors out



`endif

// ==== ctrl_pkg.sv ====
package ctrl_pkg;

   // Host bus
   typedef logic [15:0] bus_addr_t;   // Byte address
   typedef logic [31:0] bus_data_t;

   // Settings bus
   typedef logic [7:0]  set_addr_t;   // Word address within settings region
   typedef logic [31:0] set_data_t;

   // VITA time as seconds and ticks within the second
   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } vita_time_s;

   // Same 64 bits seen as two readback words
   // w[1] holds seconds, w[0] holds ticks
   typedef union packed {
      vita_time_s       t;
      logic [1:0][31:0] w;
   } vita_time_u;

endpackage

// ==== host_bus_decoder.sv ====
`include "ctrl_params.svh"

module host_bus_decoder (
   input  logic                dsp_clk,
   input  logic                por_rst,
   input  ctrl_pkg::bus_addr_t bus_adr_i,
   input  logic                bus_stb_i,
   input  logic                set_ack_i,
   input  logic                rb_ack_i,
   input  ctrl_pkg::bus_data_t rb_dat_i,
   output logic                set_sel_o,
   output logic                rb_sel_o,
   output ctrl_pkg::bus_data_t bus_dat_o,
   output logic                bus_ack_o,
   output logic                bus_err_o
);

   logic [3:0] region;
   logic       set_hit;
   logic       rb_hit;
   logic       miss;

   assign region  = bus_adr_i[15:12];
   assign set_hit = (region == `SET_REGION);
   assign rb_hit  = (region == `RB_REGION);
   assign miss    = bus_stb_i & ~set_hit & ~rb_hit;

   // Slave selects, only while the host strobes
   assign set_sel_o = bus_stb_i & set_hit;
   assign rb_sel_o  = bus_stb_i & rb_hit;

   // Only one slave acks at a time
   assign bus_ack_o = set_ack_i | rb_ack_i;
   assign bus_dat_o = rb_ack_i ? rb_dat_i : '0;   // Settings region reads back 0

   ////////////////////////////////////////////////////////////////////////////
   // Unmapped access

   // One pulse per access, same slot as a normal ack.
   // The host drops its strobe once it has seen the error.
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         bus_err_o <= 1'b0;
      end else begin
         bus_err_o <= miss & ~bus_err_o;
      end
   end

endmodule

// ==== misc_setting_regs.sv ====
`include "ctrl_params.svh"

module misc_setting_regs (
   input  logic                dsp_clk,
   input  logic                por_rst,
   input  logic                set_stb_i,
   input  ctrl_pkg::set_addr_t set_addr_i,
   input  ctrl_pkg::set_data_t set_data_i,
   input  logic                clk_status_i,
   input  logic                good_sync_i,
   output logic                clock_ready_o,
   output logic [1:0]          clk_en_o,
   output logic [1:0]          clk_sel_o,
   output logic                phy_resetn_o,
   output logic                divsw1_o,
   output logic                divsw2_o,
   output logic [7:0]          leds_o
);
   import ctrl_pkg::*;

   localparam set_addr_t ADDR_CLK     = set_addr_t'(`SR_MISC + 0);
   localparam set_addr_t ADDR_LED_SW  = set_addr_t'(`SR_MISC + 3);
   localparam set_addr_t ADDR_PHY     = set_addr_t'(`SR_MISC + 4);
   localparam set_addr_t ADDR_LED_SRC = set_addr_t'(`SR_MISC + 6);
   localparam set_addr_t ADDR_DIVSW1  = set_addr_t'(`SR_DIVSW + 0);
   localparam set_addr_t ADDR_DIVSW2  = set_addr_t'(`SR_DIVSW + 1);

   logic [4:0] clk_ctrl;    // {ready, en[1:0], sel[1:0]}
   logic       phy_reset;
   logic [7:0] led_sw;
   logic [7:0] led_src;     // 1 = hardware drives the LED
   logic [7:0] led_hw;

   ////////////////////////////////////////////////////////////////////////////
   // Setting registers

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clk_ctrl  <= '0;
         phy_reset <= 1'b0;
         divsw1_o  <= 1'b1;
         divsw2_o  <= 1'b1;
         led_sw    <= '0;
         led_src   <= `LED_SRC_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            ADDR_CLK:     clk_ctrl  <= set_data_i[4:0];
            ADDR_LED_SW:  led_sw    <= set_data_i[7:0];
            ADDR_PHY:     phy_reset <= set_data_i[0];
            ADDR_LED_SRC: led_src   <= set_data_i[7:0];
            ADDR_DIVSW1:  divsw1_o  <= set_data_i[0];
            ADDR_DIVSW2:  divsw2_o  <= set_data_i[0];
            default: ;                            // Not ours
         endcase
      end
   end

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clk_ctrl;

   // PHY reset pin is active low
   assign phy_resetn_o = ~phy_reset;

   ////////////////////////////////////////////////////////////////////////////
   // LED mux

   assign led_hw = {5'b0, good_sync_i, clk_status_i, 1'b0};

   // Per bit choice between hardware and software value
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// ==== readback_mux.sv ====
`include "ctrl_params.svh"

module readback_mux (
   input  logic                 dsp_clk,
   input  logic                 por_rst,
   input  ctrl_pkg::bus_addr_t  bus_adr_i,
   input  logic                 rb_sel_i,
   input  ctrl_pkg::vita_time_u vita_time_i,
   input  ctrl_pkg::vita_time_u vita_time_pps_i,
   input  logic                 good_sync_i,
   input  logic                 clk_status_i,
   input  logic                 button_i,
   output logic                 rb_ack_o,
   output ctrl_pkg::bus_data_t  rb_dat_o
);
   import ctrl_pkg::*;

   logic [3:0] word_sel;
   logic       take;
   bus_data_t  status_word;
   bus_data_t  word_mux;

   assign word_sel = bus_adr_i[5:2];
   assign take     = rb_sel_i & ~rb_ack_o;

   // Button at 13, clk_status at 11, good_sync at 10
   assign status_word = {18'b0, button_i, 1'b0, clk_status_i, good_sync_i, 10'b0};

   always_comb begin
      case (word_sel)
         4'd10:   word_mux = vita_time_i.w[1];        // Seconds
         4'd11:   word_mux = vita_time_i.w[0];        // Ticks
         4'd12:   word_mux = {`COMPAT_MAJOR, `COMPAT_MINOR};
         4'd13:   word_mux = status_word;
         4'd14:   word_mux = vita_time_pps_i.w[1];
         4'd15:   word_mux = vita_time_pps_i.w[0];
         default: word_mux = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_ack_o <= 1'b0;
      end else begin
         rb_ack_o <= take;                        // One ack per access
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (take)
         rb_dat_o <= word_mux;
   end

endmodule

// ==== settings_bus.sv ====
module settings_bus (
   input  logic                dsp_clk,
   input  logic                por_rst,
   input  ctrl_pkg::bus_addr_t bus_adr_i,
   input  ctrl_pkg::bus_data_t bus_dat_i,
   input  logic                bus_we_i,
   input  logic                set_sel_i,
   output logic                set_ack_o,
   output logic                set_stb_o,
   output ctrl_pkg::set_addr_t set_addr_o,
   output ctrl_pkg::set_data_t set_data_o
);

   logic take;

   // First cycle of a settings access
   assign take = set_sel_i & ~set_ack_o;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         set_ack_o <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         set_ack_o <= take;               // Reads are acked too
         set_stb_o <= take & bus_we_i;    // Lines up with the ack
      end
   end

   // Byte address to word address
   always_ff @(posedge dsp_clk) begin
      if (take) begin
         set_addr_o <= bus_adr_i[9:2];
         set_data_o <= bus_dat_i;
      end
   end

endmodule

// ==== vita_time_counter.sv ====
`include "ctrl_params.svh"

module vita_time_counter (
   input  logic                 dsp_clk,
   input  logic                 por_rst,
   input  logic                 set_stb_i,
   input  ctrl_pkg::set_addr_t  set_addr_i,
   input  ctrl_pkg::set_data_t  set_data_i,
   input  logic                 pps_i,
   output ctrl_pkg::vita_time_u vita_time_o,
   output ctrl_pkg::vita_time_u vita_time_pps_o,
   output logic                 good_sync_o,
   output logic                 pps_int_o
);
   import ctrl_pkg::*;

   localparam set_addr_t ADDR_SECS  = set_addr_t'(`SR_TIME64 + 0);
   localparam set_addr_t ADDR_TICKS = set_addr_t'(`SR_TIME64 + 1);
   localparam set_addr_t ADDR_LOAD  = set_addr_t'(`SR_TIME64 + 2);

   vita_time_u staged;      // Time to load, now or at PPS
   vita_time_u time_q;
   logic       load_armed;
   logic       load_cmd;
   logic       last_tick;
   logic       pps_s1;
   logic       pps_s2;
   logic       pps_d;
   logic       pps_edge;

   assign load_cmd  = set_stb_i & (set_addr_i == ADDR_LOAD);
   assign last_tick = (time_q.t.ticks == `TICKS_PER_SEC - 32'd1);

   always_ff @(posedge dsp_clk) begin
      if (set_stb_i && set_addr_i == ADDR_SECS)
         staged.t.secs <= set_data_i;
      if (set_stb_i && set_addr_i == ADDR_TICKS)
         staged.t.ticks <= set_data_i;
   end

   ////////////////////////////////////////////////////////////////////////////
   // PPS synchronizer and rising edge

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_s1 <= 1'b0;
         pps_s2 <= 1'b0;
         pps_d  <= 1'b0;
      end else begin
         pps_s1 <= pps_i;
         pps_s2 <= pps_s1;
         pps_d  <= pps_s2;
      end
   end

   assign pps_edge = pps_s2 & ~pps_d;

   ////////////////////////////////////////////////////////////////////////////
   // Time counter

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_q          <= '0;
         vita_time_pps_o <= '0;
         load_armed      <= 1'b0;
         good_sync_o     <= 1'b0;
         pps_int_o       <= 1'b0;
      end else begin
         pps_int_o <= pps_edge;

         if (last_tick) begin
            time_q.t.ticks <= '0;
            time_q.t.secs  <= time_q.t.secs + 32'd1;
         end else begin
            time_q.t.ticks <= time_q.t.ticks + 32'd1;
         end

         if (pps_edge) begin
            vita_time_pps_o <= time_q;         // Time before any load
            if (load_armed) begin
               time_q      <= staged;
               load_armed  <= 1'b0;
               good_sync_o <= 1'b1;
            end
         end

         // Command from software wins over the PPS path
         if (load_cmd) begin
            if (set_data_i[0]) begin
               time_q      <= staged;          // Immediate, no PPS alignment
               load_armed  <= 1'b0;
               good_sync_o <= 1'b0;
            end else begin
               load_armed  <= 1'b1;
            end
         end
      end
   end

   assign vita_time_o = time_q;

endmodule
